// ==== Makefile ====
TOP = tb_fetch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir

// ==== list.f ====
src/icache_pkg.sv
src/fetch_pkg.sv
src/pc_track_fifo.sv
src/if1_stage.sv
src/inst_queue.sv
src/fetch_top.sv
testbench/tb_fetch.sv

// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // aligned packet, same layout as the cache response
    // inst0 always holds the word at pc
    typedef struct packed {
        logic [31:0]                   pc;
        logic [31:0]                   pc_next;
        logic                          taken;
        logic [31:0]                   inst0;
        logic [31:0]                   inst1;
        logic [31:0]                   badv;
        logic [icache_pkg::EXC_W-1:0]  exception;
        logic [icache_pkg::EXCF_W-1:0] excp_flag;
    } fetch_pkt_t;

    // skid buffer state
    // held: a response parked behind the stage register
    // drain: skid moved on, waiting for queue space before new fetches
    typedef enum logic [1:0] {
        skid_empty = 2'b00,
        skid_held  = 2'b01,
        skid_drain = 2'b10
    } skid_state_e;

endpackage

`default_nettype wire

// ==== src/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter int PC_DEPTH = 4,
    parameter int Q_DEPTH  = 8,
    parameter int INFLIGHT = 2
) (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire logic                     flush,
    input  wire logic                     fetch_req,
    input  wire logic [31:0]              fetch_pc,
    input  wire logic                     resp_valid,
    input  wire icache_pkg::icache_resp_t resp,
    input  wire logic                     pop_en,
    output logic                          if1_allowin,
    output logic                          out_valid,
    output fetch_pkg::fetch_pkt_t         out_pkt
);

    // stage to queue
    logic                  stage_valid;
    fetch_pkg::fetch_pkt_t stage_pkt;
    // queue back to stage
    logic                  q_allowin;
    logic                  space_ok;

    if1_stage #(
        .PC_DEPTH (PC_DEPTH),
        .INFLIGHT (INFLIGHT)
    ) u_if1_stage (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .q_allowin   (q_allowin),
        .space_ok    (space_ok),
        .if1_allowin (if1_allowin),
        .stage_valid (stage_valid),
        .stage_pkt   (stage_pkt)
    );

    inst_queue #(
        .DEPTH    (Q_DEPTH),
        .INFLIGHT (INFLIGHT)
    ) u_inst_queue (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .push_valid (stage_valid),
        .push_pkt   (stage_pkt),
        .pop_en     (pop_en),
        .q_allowin  (q_allowin),
        .space_ok   (space_ok),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt)
    );

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // exception code and flag widths from the cache
    localparam int EXC_W  = 7;
    localparam int EXCF_W = 2;

    // no-op word for empty slots
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    // one cache response, two-word bundle
    typedef struct packed {
        logic [31:0]       pc;
        logic [31:0]       pc_next;
        logic              taken;
        logic [31:0]       inst0;
        logic [31:0]       inst1;
        // faulting address
        logic [31:0]       badv;
        logic [EXC_W-1:0]  exception;
        logic [EXCF_W-1:0] excp_flag;
    } icache_resp_t;

endpackage

`default_nettype wire

// ==== src/if1_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module if1_stage #(
    parameter int PC_DEPTH = 4,
    parameter int INFLIGHT = 2
) (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire logic                     flush,
    input  wire logic                     fetch_req,
    input  wire logic [31:0]              fetch_pc,
    input  wire logic                     resp_valid,
    input  wire icache_pkg::icache_resp_t resp,
    input  wire logic                     q_allowin,
    input  wire logic                     space_ok,
    output logic                          if1_allowin,
    output logic                          stage_valid,
    output fetch_pkg::fetch_pkt_t         stage_pkt
);

    logic [31:0]            trk_head;
    logic                   trk_full;
    logic                   trk_empty;
    logic                   resp_match;
    logic [INFLIGHT-1:0]    fetch_hist;
    fetch_pkg::skid_state_e skid_state;
    fetch_pkg::fetch_pkt_t  skid_pkt;
    fetch_pkg::fetch_pkt_t  resp_pkt;
    logic                   stage_free;
    logic                   skid_full;
    logic                   stage_load;
    logic                   skid_load;

    // pc[2] set: upper word moves down, second slot becomes a nop
    function automatic fetch_pkg::fetch_pkt_t align_resp(input icache_pkg::icache_resp_t r);
        fetch_pkg::fetch_pkt_t p;
        p.pc        = r.pc;
        p.pc_next   = r.pc_next;
        p.taken     = r.taken;
        p.badv      = r.badv;
        p.exception = r.exception;
        p.excp_flag = r.excp_flag;
        if (r.pc[2]) begin
            p.inst0 = r.inst1;
            p.inst1 = icache_pkg::INST_NOP;
        end else begin
            p.inst0 = r.inst0;
            p.inst1 = r.inst1;
        end
        return p;
    endfunction

    // addresses the cache has accepted, oldest at the head
    pc_track_fifo #(
        .DATA_WIDTH (32),
        .DEPTH      (PC_DEPTH)
    ) u_pc_track_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .flush (flush),
        .push  (fetch_req),
        .din   (fetch_pc),
        .pop   (resp_match),
        .dout  (trk_head),
        .full  (trk_full),
        .empty (trk_empty)
    );

    // only the oldest outstanding pc is accepted, anything else is stale
    assign resp_match = resp_valid && !trk_empty && (resp.pc == trk_head);
    assign resp_pkt   = align_resp(resp);

    // stage frees up when empty or when the queue takes it this cycle
    assign stage_free = !stage_valid || q_allowin;
    assign skid_full  = (skid_state == fetch_pkg::skid_held);
    // skid goes first so order is kept
    assign stage_load = stage_free && (skid_full || resp_match);
    // new response parks in skid if stage busy or skid still ahead of it
    assign skid_load  = resp_match && (skid_full || !stage_free);

    assign if1_allowin = space_ok && (skid_state == fetch_pkg::skid_empty) && !trk_full;

    // recent fetches, a response can still come back while any bit is set
    // the cache pipe is not flushed, so neither is this
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_hist <= '0;
        end else begin
            fetch_hist[0] <= fetch_req;
            for (int i = 1; i < INFLIGHT; i++) begin
                fetch_hist[i] <= fetch_hist[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stage_valid <= 1'b0;
            skid_state  <= fetch_pkg::skid_empty;
        end else if (flush) begin
            stage_valid <= 1'b0;
            skid_state  <= fetch_pkg::skid_empty;
        end else begin
            if (stage_load) begin
                stage_valid <= 1'b1;
            end else if (q_allowin) begin
                stage_valid <= 1'b0;
            end
            if (skid_load) begin
                skid_state <= fetch_pkg::skid_held;
            end else if (skid_full && stage_free) begin
                skid_state <= fetch_pkg::skid_drain;
            end else if (skid_state == fetch_pkg::skid_drain && space_ok) begin
                skid_state <= fetch_pkg::skid_empty;
            end
        end
    end

    // payload, valid bits above qualify it
    always_ff @(posedge clk) begin
        if (stage_load) begin
            stage_pkt <= skid_full ? skid_pkt : resp_pkt;
        end
        if (skid_load) begin
            skid_pkt <= resp_pkt;
        end
    end

    // a response needs an outstanding address or a fetch still in the cache pipe
    a_resp_expected: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> (!trk_empty || (|fetch_hist)));

    // queue space check must leave room so the skid never overflows
    a_skid_no_overrun: assert property (@(posedge clk) disable iff (!rstn || flush)
        !(resp_match && skid_full && !stage_free));

endmodule

`default_nettype wire

// ==== src/inst_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_queue #(
    parameter int DEPTH    = 8,
    parameter int INFLIGHT = 2
) (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  flush,
    input  wire logic                  push_valid,
    input  wire fetch_pkg::fetch_pkt_t push_pkt,
    input  wire logic                  pop_en,
    output logic                       q_allowin,
    output logic                       space_ok,
    output logic                       out_valid,
    output fetch_pkg::fetch_pkt_t      out_pkt
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;
    // highest count that still leaves INFLIGHT + 1 free entries
    localparam logic [CNT_W-1:0] SPACE_LIM = CNT_W'(DEPTH - INFLIGHT - 1);

    fetch_pkg::fetch_pkt_t mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  do_push;
    logic                  do_pop;

    assign q_allowin = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    // room for the stage register and every response in flight
    assign space_ok  = (count <= SPACE_LIM);

    assign do_push = push_valid && q_allowin;
    assign do_pop  = pop_en && out_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    // head read straight from the array, decoder sees it this cycle
    assign out_pkt = mem[rd_ptr];

    // the head holds still until the decoder takes it
    a_head_stable: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && !pop_en && !flush) |=> $stable(out_pkt));

endmodule

`default_nettype wire

// ==== src/pc_track_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_track_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 4
) (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  flush,
    input  wire logic                  push,
    input  wire logic [DATA_WIDTH-1:0] din,
    input  wire logic                  pop,
    output logic      [DATA_WIDTH-1:0] dout,
    output logic                       full,
    output logic                       empty
);

    // depth is a power of two, pointers wrap on their own
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // drop every outstanding address
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // oldest outstanding address
    assign dout  = mem[rd_ptr];
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // stage throttles fetches on full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        !(push && full && !flush));

    // stage only pops on a head match
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        !(pop && empty));

endmodule

`default_nettype wire

// ==== testbench/tb_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;

    localparam int INFLIGHT = 2;

    // one fetch still inside the cache model
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] due;
        logic        live;
    } pend_t;

    logic                     clk;
    logic                     rstn;
    logic                     flush;
    logic                     fetch_req;
    logic [31:0]              fetch_pc;
    logic                     resp_valid;
    icache_pkg::icache_resp_t resp;
    logic                     pop_en;
    logic                     if1_allowin;
    logic                     out_valid;
    fetch_pkg::fetch_pkt_t    out_pkt;

    integer      seed;
    logic [31:0] cyc;
    logic [31:0] last_due;
    logic [27:0] pc_seq;
    int          checks;
    int          errors;
    int          popped;
    int          aligned;
    int          stale_sent;
    int          stalls;
    int          total_popped;
    // cache pipe, oldest first
    pend_t                 pend_q[$];
    // packets the decoder should see, in order
    fetch_pkg::fetch_pkt_t exp_q[$];

    fetch_top #(
        .PC_DEPTH (4),
        .Q_DEPTH  (8),
        .INFLIGHT (INFLIGHT)
    ) u_fetch_top (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .pop_en      (pop_en),
        .if1_allowin (if1_allowin),
        .out_valid   (out_valid),
        .out_pkt     (out_pkt)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // true pct times out of a hundred
    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = rand_word();
        return (r % 32'd100) < 32'(pct);
    endfunction

    // same layout, then word shift when the fetch starts in the upper half
    function automatic fetch_pkg::fetch_pkt_t expect_pkt(input icache_pkg::icache_resp_t r);
        fetch_pkg::fetch_pkt_t e;
        e = fetch_pkg::fetch_pkt_t'(r);
        if (r.pc[2]) begin
            e.inst0 = r.inst1;
            e.inst1 = icache_pkg::INST_NOP;
        end
        return e;
    endfunction

    task automatic check_pkt(input string name, input fetch_pkg::fetch_pkt_t got,
                             input fetch_pkg::fetch_pkt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    // one clock of cache, fetch and decoder activity at the falling edge
    task automatic step(input int fetch_pct, input int stale_pct, input int pop_pct,
                        input int flush_pct);
        icache_pkg::icache_resp_t r;
        pend_t                    p;
        logic                     do_flush;
        logic                     do_pop;
        logic [31:0]              w;
        @(negedge clk);
        cyc++;
        if (!if1_allowin) begin
            stalls++;
        end
        // flush driven last cycle, everything must be empty now
        if (flush) begin
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("if1_allowin", if1_allowin, 1'b1);
        end else if (out_valid && exp_q.size() == 0) begin
            check_bit("out_valid", out_valid, 1'b0);
        end
        do_flush = chance(flush_pct);
        do_pop   = out_valid && !do_flush && chance(pop_pct);
        if (do_pop && exp_q.size() != 0) begin
            if (out_pkt.pc[2]) begin
                aligned++;
            end
            check_pkt("out_pkt", out_pkt, exp_q.pop_front());
            popped++;
        end
        if (do_flush) begin
            exp_q.delete();
            // in-flight responses still come back but must be dropped
            for (int i = 0; i < pend_q.size(); i++) begin
                p        = pend_q[i];
                p.live   = 1'b0;
                pend_q[i] = p;
            end
        end
        // random payload for whatever goes out this cycle
        w           = rand_word();
        r.pc_next   = rand_word();
        r.taken     = w[0];
        r.inst0     = rand_word();
        r.inst1     = rand_word();
        r.badv      = rand_word();
        r.exception = w[7:1];
        r.excp_flag = w[9:8];
        resp_valid  = 1'b0;
        if (pend_q.size() != 0 && pend_q[0].due == cyc) begin
            p          = pend_q.pop_front();
            r.pc       = p.pc;
            resp       = r;
            resp_valid = 1'b1;
            if (p.live) begin
                exp_q.push_back(expect_pkt(r));
            end
        end else if (pend_q.size() != 0 && chance(stale_pct)) begin
            // bit 31 set, never a real fetch address
            r.pc       = {1'b1, w[30:3], w[10], 2'b00};
            resp       = r;
            resp_valid = 1'b1;
            stale_sent++;
        end
        fetch_req = 1'b0;
        if (!do_flush && if1_allowin && chance(fetch_pct)) begin
            pc_seq++;
            w         = rand_word();
            fetch_pc  = {1'b0, pc_seq, w[0], 2'b00};
            fetch_req = 1'b1;
            // 1 to INFLIGHT cycles, responses stay in order
            p.pc   = fetch_pc;
            p.live = 1'b1;
            p.due  = cyc + 32'd1 + (rand_word() % 32'(INFLIGHT));
            if (p.due <= last_due) begin
                p.due = last_due + 32'd1;
            end
            last_due = p.due;
            pend_q.push_back(p);
        end
        flush  = do_flush;
        pop_en = do_pop;
    endtask

    // no new fetches, pop every cycle until all is out
    task automatic drain(input int limit);
        int n;
        n = 0;
        while ((pend_q.size() != 0 || exp_q.size() != 0 || !if1_allowin) && n < limit) begin
            step(0, 0, 100, 0);
            n++;
        end
        if (pend_q.size() != 0 || exp_q.size() != 0 || !if1_allowin) begin
            errors++;
            $display("drain timed out after %0d cycles, %0d packets never came out",
                     limit, exp_q.size());
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s: %0d popped, %0d aligned, %0d stale, %0d errors",
                 name, popped, aligned, stale_sent, errors - err_before);
        total_popped += popped;
        popped     = 0;
        aligned    = 0;
        stale_sent = 0;
        stalls     = 0;
    endtask

    initial begin
        int err0;
        seed       = 24326;
        clk        = 1'b0;
        rstn       = 1'b0;
        flush      = 1'b0;
        fetch_req  = 1'b0;
        fetch_pc   = '0;
        resp_valid = 1'b0;
        resp       = '0;
        pop_en     = 1'b0;
        cyc        = '0;
        last_due   = '0;
        pc_seq     = '0;
        checks     = 0;
        errors     = 0;
        popped     = 0;
        aligned    = 0;
        stale_sent = 0;
        stalls     = 0;
        total_popped = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        err0 = errors;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("if1_allowin", if1_allowin, 1'b1);
        report_test("reset", err0);

        // decoder always ready
        err0 = errors;
        repeat (300) step(70, 0, 100, 0);
        drain(100);
        if (aligned == 0 || popped == 0) begin
            errors++;
            $display("stream test saw no packets with pc bit 2 set");
        end
        report_test("stream", err0);

        err0 = errors;
        repeat (300) step(70, 30, 100, 0);
        drain(100);
        if (stale_sent == 0 || popped == 0) begin
            errors++;
            $display("stale test sent no stale responses or saw no packets");
        end
        report_test("stale", err0);

        // slow decoder, queue fills and the skid gets used
        err0 = errors;
        repeat (600) step(90, 20, 30, 0);
        if (stalls == 0) begin
            errors++;
            $display("backpress test never saw the stage stop taking fetches");
        end
        drain(200);
        report_test("backpress", err0);

        err0 = errors;
        repeat (400) step(80, 10, 60, 3);
        drain(200);
        report_test("flush", err0);

        $display("checks %0d, errors %0d, packets %0d", checks, errors, total_popped);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
